// File: include/itag_params.svh
// ================================================
// Width and size macros for the instruction cache
// tag store: address split and set count
// ================================================

`ifndef ITAG_PARAMS_SVH
`define ITAG_PARAMS_SVH

// Fetch address and its fields, tag | index | offset
`define ITAG_ADDR_W    32
`define ITAG_TAG_W     23
`define ITAG_INDEX_W   6
`define ITAG_OFFSET_W  3  // Byte within line, ignored by the tag store

// Tag memory depth, one entry pair per set
`define ITAG_SETS      64

`endif

// File: design/itag_pkg.sv
// ================================================
// Vector types shared by the tag store blocks
// ================================================

`include "itag_params.svh"

package itag_pkg;

  // Fetch address as seen by the cache
  typedef logic [`ITAG_ADDR_W-1:0] addr_t;

  // Upper address bits kept per way
  typedef logic [`ITAG_TAG_W-1:0] tag_t;

  // Set selector
  typedef logic [`ITAG_INDEX_W-1:0] index_t;

  // One way entry, valid on top, tag below
  typedef logic [`ITAG_TAG_W:0] entry_t;

  // Full set row, way1 in the high half
  typedef logic [2*(`ITAG_TAG_W+1)-1:0] set_t;

  // Per-way write enable
  typedef logic [1:0] wmask_t;  // Bit 0 is way0

endpackage

// File: design/itag_if.sv
// ================================================
// Internal bus of the tag store: set read-out,
// LRU bit and LRU update between the three blocks
// ================================================

`timescale 1ns/100ps

interface itag_if;
  import itag_pkg::*;

  set_t   set_data;   // Row read from the tag memory
  logic   lru_bit;    // Way to evict when both valid

  // LRU write-back from the hit selector
  logic   upd_en;
  index_t upd_index;
  logic   upd_lru;    // New bit, the way not just used

  // Tag memory only sources the row
  modport sram_mp (
    output set_data
  );

  // LRU array reads updates, returns the bit
  modport lru_mp (
    output lru_bit,
    input  upd_en,
    input  upd_index,
    input  upd_lru
  );

  // Hit selector consumes both, issues updates
  modport sel_mp (
    input  set_data,
    input  lru_bit,
    output upd_en,
    output upd_index,
    output upd_lru
  );

endinterface

// File: design/tag_sram.sv
// ================================================
// Two-way tag memory, 64 sets by 48 bits
// Inputs registered on the rising edge, array
// written or read on the following falling edge
// ================================================

`timescale 1ns/100ps

`include "itag_params.svh"

module tag_sram (
  input  logic             clk0,
  input  logic             init,
  itag_if.sram_mp          tag_bus,
  input  logic             csb,     // Select, active low
  input  logic             web,     // Write, active low
  input  itag_pkg::wmask_t wmask,
  input  itag_pkg::index_t index,
  input  itag_pkg::set_t   din
);
  import itag_pkg::*;

  localparam int ENTRY_W = $bits(entry_t);  // One way per half row

  set_t   mem [`ITAG_SETS];

  // Registered copy of the port
  logic   csb_q;
  logic   web_q;
  wmask_t wmask_q;
  index_t index_q;
  set_t   din_q;

  // Control side of the input register
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      csb_q <= 1'b1;  // Deselected
      web_q <= 1'b1;
    end else begin
      csb_q <= csb;
      web_q <= web;
    end
  end

  // Address, mask and data captured each cycle
  always_ff @(posedge clk0) begin
    wmask_q <= wmask;
    index_q <= index;
    din_q   <= din;
  end

  // Array access half a cycle after capture
  // so the read data is ready by the next rising edge
  always_ff @(negedge clk0 or posedge init) begin
    if (init) begin
      for (int i = 0; i < `ITAG_SETS; i++) begin
        mem[i] <= '0;  // All ways invalid
      end
      tag_bus.set_data <= '0;
    end else if (!csb_q) begin
      if (!web_q) begin
        // Each way written alone
        if (wmask_q[0]) begin
          mem[index_q][ENTRY_W-1:0] <= din_q[ENTRY_W-1:0];
        end
        if (wmask_q[1]) begin
          mem[index_q][2*ENTRY_W-1:ENTRY_W] <= din_q[2*ENTRY_W-1:ENTRY_W];
        end
      end else begin
        tag_bus.set_data <= mem[index_q];  // Held until the next read
      end
    end
  end

endmodule

// File: design/lru_array.sv
// ================================================
// Pseudo-LRU bits, one per set, registered read
// index with forwarding of same-set updates
// ================================================

`timescale 1ns/100ps

`include "itag_params.svh"

module lru_array (
  input  logic             clk0,
  input  logic             init,
  itag_if.lru_mp           tag_bus,
  input  logic             rd_en,
  input  itag_pkg::index_t rd_index
);
  import itag_pkg::*;

  logic [`ITAG_SETS-1:0] lru_mem;     // 1 means way1 is next victim
  index_t                rd_index_q;
  logic                  fwd_hit;     // Pending update targets read set

  // Update port, written on the rising edge
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      lru_mem <= '0;  // Way0 first after reset
    end else if (tag_bus.upd_en) begin
      lru_mem[tag_bus.upd_index] <= tag_bus.upd_lru;
    end
  end

  // Read index held between lookups
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      rd_index_q <= '0;
    end else if (rd_en) begin
      rd_index_q <= rd_index;
    end
  end

  // An update on the bus lands at the same edge
  // the reader samples, so pass it straight through
  assign fwd_hit = tag_bus.upd_en && (tag_bus.upd_index == rd_index_q);

  assign tag_bus.lru_bit = fwd_hit ? tag_bus.upd_lru : lru_mem[rd_index_q];

endmodule

// File: design/hit_select.sv
// ================================================
// Tag compare, hit and victim choice, registered
// response and LRU write-back
// ================================================

`timescale 1ns/100ps

module hit_select (
  input  logic             clk0,
  input  logic             init,
  itag_if.sel_mp           tag_bus,
  input  logic             lookup_q,   // Lookup, already fill-qualified
  input  logic             fill_q,
  input  itag_pkg::tag_t   req_tag,
  input  itag_pkg::index_t req_index,
  input  logic             fill_way,
  output logic             resp_valid,
  output logic             hit,
  output logic             hit_way,
  output logic             victim_way
);
  import itag_pkg::*;

  localparam int ENTRY_W = $bits(entry_t);
  localparam int TAG_W   = $bits(tag_t);

  // Request copy, aligned with the memory read-out
  logic   lookup_r;
  logic   fill_r;
  tag_t   tag_r;
  index_t index_r;
  logic   fill_way_r;

  entry_t way0;
  entry_t way1;
  logic   match0;
  logic   match1;
  logic   hit_c;
  logic   hit_way_c;
  logic   victim_c;

  assign way0 = tag_bus.set_data[ENTRY_W-1:0];
  assign way1 = tag_bus.set_data[2*ENTRY_W-1:ENTRY_W];

  assign match0 = way0[TAG_W] && (way0[TAG_W-1:0] == tag_r);
  assign match1 = way1[TAG_W] && (way1[TAG_W-1:0] == tag_r);

  assign hit_c     = match0 | match1;
  assign hit_way_c = match1 && !match0;  // Way0 wins a double match

  // Hit leaves the other way as victim, else first invalid, else LRU
  always_comb begin
    if (hit_c)             victim_c = !hit_way_c;
    else if (!way0[TAG_W]) victim_c = 1'b0;
    else if (!way1[TAG_W]) victim_c = 1'b1;
    else                   victim_c = tag_bus.lru_bit;
  end

  // Strobes and the outgoing pulses
  always_ff @(posedge clk0 or posedge init) begin
    if (init) begin
      lookup_r       <= 1'b0;
      fill_r         <= 1'b0;
      resp_valid     <= 1'b0;
      tag_bus.upd_en <= 1'b0;
    end else begin
      lookup_r       <= lookup_q;
      fill_r         <= fill_q;
      resp_valid     <= lookup_r;                      // One cycle after capture
      tag_bus.upd_en <= fill_r || (lookup_r && hit_c);  // Misses leave LRU alone
    end
  end

  // Request fields and response payload
  always_ff @(posedge clk0) begin
    tag_r             <= req_tag;
    index_r           <= req_index;
    fill_way_r        <= fill_way;
    hit               <= lookup_r && hit_c;
    hit_way           <= hit_way_c;
    victim_way        <= victim_c;
    tag_bus.upd_index <= index_r;
    tag_bus.upd_lru   <= fill_r ? !fill_way_r : !hit_way_c;  // Point away from last use
  end

endmodule

// File: design/itag_top.sv
// ================================================
// Instruction cache tag store top level
// Address split, strobe qualify, block wiring
// ================================================

`timescale 1ns/100ps

`include "itag_params.svh"

module itag_top (
  input  logic            clk0,
  input  logic            init,
  input  logic            lookup,
  input  logic            fill,
  input  itag_pkg::addr_t addr,
  input  logic            fill_way,
  output logic            resp_valid,
  output logic            hit,
  output logic            hit_way,
  output logic            victim_way
);
  import itag_pkg::*;

  logic   lookup_q;    // Lookup with fill priority applied
  logic   fill_q;
  tag_t   req_tag;
  index_t req_index;
  entry_t fill_entry;

  // Tag memory port, active-low controls
  logic   csb;
  logic   web;
  wmask_t wmask;
  set_t   din;

  itag_if tag_bus ();

  // Fill wins, a colliding lookup is dropped
  assign fill_q   = fill;
  assign lookup_q = lookup && !fill;

  // Line offset bits never reach the tag store
  assign req_tag   = addr[`ITAG_ADDR_W-1 -: `ITAG_TAG_W];
  assign req_index = addr[`ITAG_OFFSET_W +: `ITAG_INDEX_W];

  assign csb   = !(lookup_q || fill_q);
  assign web   = !fill_q;                              // Lookup reads
  assign wmask = fill_way ? 2'b10 : 2'b01;             // One way per fill

  // New valid entry placed in the named way's half
  assign fill_entry = {1'b1, req_tag};
  assign din = fill_way ? {fill_entry, entry_t'('0)} : {entry_t'('0), fill_entry};

  tag_sram tag_sram_i (
    .clk0    (clk0),
    .init    (init),
    .tag_bus (tag_bus.sram_mp),
    .csb     (csb),
    .web     (web),
    .wmask   (wmask),
    .index   (req_index),
    .din     (din)
  );

  // Only lookups need the replacement bit
  lru_array lru_array_i (
    .clk0     (clk0),
    .init     (init),
    .tag_bus  (tag_bus.lru_mp),
    .rd_en    (lookup_q),
    .rd_index (req_index)
  );

  hit_select hit_select_i (
    .clk0       (clk0),
    .init       (init),
    .tag_bus    (tag_bus.sel_mp),
    .lookup_q   (lookup_q),
    .fill_q     (fill_q),
    .req_tag    (req_tag),
    .req_index  (req_index),
    .fill_way   (fill_way),
    .resp_valid (resp_valid),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

endmodule

// File: testbench/tb_itag.sv
// ================================================
// Testbench for the tag store: clock and reset,
// LFSR stimulus over pooled tags, reference model,
// response compare and cycle timeout
// ================================================

`timescale 1ns/100ps

`include "itag_params.svh"

module tb_itag;
  import itag_pkg::*;

  localparam int RESET_CYCLES    = 8;
  localparam int DIRECTED_CYCLES = 60;    // Upper bound of the directed part
  localparam int RANDOM_OPS      = 2000;
  localparam int STIM_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_OPS;
  localparam int CYCLE_LIMIT     = 2 * STIM_CYCLES + 50;

  localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32+x^22+x^2+x+1

  // One expected lookup response
  typedef struct packed {
    logic [31:0] due;     // Cycle count when resp_valid shows it
    logic        hit;
    logic        way;
    logic        victim;
  } expect_t;

  logic  clk0;
  logic  init;
  logic  lookup;
  logic  fill;
  addr_t addr;
  logic  fill_way;
  logic  resp_valid;
  logic  hit;
  logic  hit_way;
  logic  victim_way;

  logic [31:0] cycle = '0;    // Rising edges seen so far
  logic [31:0] lfsr;
  expect_t     pending [$];   // Filled by stimulus, walked by the compare process
  int          next_check = 0;

  // Reference model state
  logic m_valid [2][`ITAG_SETS];
  tag_t m_tag   [2][`ITAG_SETS];
  logic m_lru   [`ITAG_SETS];    // Way to evict when both valid

  itag_top itag_top_i (
    .clk0       (clk0),
    .init       (init),
    .lookup     (lookup),
    .fill       (fill),
    .addr       (addr),
    .fill_way   (fill_way),
    .resp_valid (resp_valid),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  always #10 clk0 = ~clk0;  // 20 ns period

  // Cycle count and run limit
  always @(posedge clk0) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ({1'b0, s[31:1]} ^ LFSR_TAPS) : {1'b0, s[31:1]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Eight sets spread over the array
  function automatic index_t pool_index(input logic [2:0] set_sel);
    pool_index = {set_sel, 3'b101};
  endfunction

  // Four distinct tags per set
  function automatic tag_t pool_tag(input logic [2:0] set_sel, input logic [1:0] slot);
    pool_tag = {slot, 5'h0d, set_sel, 13'h0a5};
  endfunction

  function automatic addr_t make_addr(input tag_t tag, input index_t idx,
                                      input logic [2:0] off);
    make_addr = {tag, idx, off};
  endfunction

  // Expected lookup result from the model state
  function automatic expect_t ref_lookup(input tag_t tag, input index_t idx,
                                         input logic [31:0] due);
    expect_t r;
    logic    m0;
    logic    m1;
    m0 = m_valid[0][idx] && (m_tag[0][idx] == tag);
    m1 = m_valid[1][idx] && (m_tag[1][idx] == tag);
    r.due = due;
    r.hit = m0 || m1;
    r.way = m1;                      // Stimulus keeps a tag in one way only
    if (r.hit) begin
      r.victim = !r.way;             // The way not just used
    end else if (!m_valid[0][idx]) begin
      r.victim = 1'b0;
    end else if (!m_valid[1][idx]) begin
      r.victim = 1'b1;
    end else begin
      r.victim = m_lru[idx];
    end
    return r;
  endfunction

  task automatic reset_model();
    for (int s = 0; s < `ITAG_SETS; s++) begin
      m_valid[0][s] = 1'b0;
      m_valid[1][s] = 1'b0;
      m_tag[0][s]   = '0;
      m_tag[1][s]   = '0;
      m_lru[s]      = 1'b0;
    end
  endtask

  // Drive one cycle on the falling edge and update the model
  task automatic issue(input logic do_lookup, input logic do_fill, input addr_t a,
                       input logic way);
    expect_t r;
    tag_t    tag;
    index_t  idx;
    @(negedge clk0);
    lookup   = do_lookup;
    fill     = do_fill;
    addr     = a;
    fill_way = way;
    tag = a[`ITAG_ADDR_W-1 -: `ITAG_TAG_W];
    idx = a[`ITAG_OFFSET_W +: `ITAG_INDEX_W];
    if (do_fill) begin
      m_valid[way][idx] = 1'b1;  // Colliding lookup dropped
      m_tag[way][idx]   = tag;
      m_lru[idx]        = !way;
    end else if (do_lookup) begin
      r = ref_lookup(tag, idx, cycle + 32'd2);  // Sampled next edge, answered one later
      pending.push_back(r);
      if (r.hit) begin
        m_lru[idx] = !r.way;
      end
    end
  endtask

  task automatic idle();
    issue(1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic check_value(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h at cycle %0d", name, got, exp, cycle);
      $display("TEST RESULT: FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // Compare each response at the falling edge, outputs settled by then
  always @(negedge clk0) begin
    if (!init) begin
      if (next_check < pending.size() && pending[next_check].due == cycle) begin
        check_value("resp_valid", resp_valid, 1'b1);
        check_value("hit", hit, pending[next_check].hit);
        if (pending[next_check].hit) begin
          check_value("hit_way", hit_way, pending[next_check].way);
        end
        check_value("victim_way", victim_way, pending[next_check].victim);
        next_check = next_check + 1;
      end else if (resp_valid) begin
        $display("Response seen at cycle %0d with no lookup waiting for it", cycle);
        $display("TEST RESULT: FAIL");
        $fatal(1, "unexpected response");
      end
    end
  end

  task automatic run_directed();
    index_t s;
    tag_t   ta;
    tag_t   tb;
    tag_t   tc;
    tag_t   td;
    s  = pool_index(3'd2);
    ta = pool_tag(3'd2, 2'd0);
    tb = pool_tag(3'd2, 2'd1);
    tc = pool_tag(3'd2, 2'd2);
    td = pool_tag(3'd2, 2'd3);
    // Cold lookups, all miss toward way0
    for (int k = 0; k < 8; k++) begin
      issue(1'b1, 1'b0, make_addr(pool_tag(3'(k), 2'd1), pool_index(3'(k)), 3'd4), 1'b0);
    end
    // Fill then hit next cycle, each way
    issue(1'b0, 1'b1, make_addr(ta, s, 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(ta, s, 3'd6), 1'b0);
    issue(1'b0, 1'b1, make_addr(tb, s, 3'd0), 1'b1);
    issue(1'b1, 1'b0, make_addr(tb, s, 3'd1), 1'b0);
    // Full set, victim follows LRU, back-to-back on one set
    issue(1'b1, 1'b0, make_addr(tc, s, 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(ta, s, 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(tc, s, 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(tb, s, 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(tc, s, 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(tb, s, 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(tb, s, 3'd0), 1'b0);
    // Overwrite way0, old tag gone
    issue(1'b0, 1'b1, make_addr(td, s, 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(ta, s, 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(td, s, 3'd0), 1'b0);
    // Fill and lookup together, lookup dropped
    issue(1'b1, 1'b1, make_addr(tc, s, 3'd0), 1'b1);
    idle();
    issue(1'b1, 1'b0, make_addr(tc, s, 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(tb, s, 3'd0), 1'b0);
    issue(1'b1, 1'b1, make_addr(pool_tag(3'd5, 2'd2), pool_index(3'd5), 3'd0), 1'b0);
    issue(1'b1, 1'b0, make_addr(pool_tag(3'd5, 2'd2), pool_index(3'd5), 3'd3), 1'b0);
    repeat (3) idle();
  endtask

  task automatic run_random();
    logic [31:0] op;
    logic [31:0] sel;
    logic [31:0] slot;
    logic [31:0] off;
    logic [31:0] way;
    index_t      idx;
    tag_t        tag;
    logic        w;
    for (int n = 0; n < RANDOM_OPS; n++) begin
      take_bits(3, op);    // 0..4 lookup, 5..6 fill, 7 both
      take_bits(3, sel);
      take_bits(2, slot);
      take_bits(3, off);
      take_bits(1, way);
      idx = pool_index(sel[2:0]);
      tag = pool_tag(sel[2:0], slot[1:0]);
      w   = way[0];
      if (m_valid[!w][idx] && (m_tag[!w][idx] == tag)) begin
        w = !w;  // Refill where the tag already lives
      end
      issue((op < 32'd5) || (op == 32'd7), op >= 32'd5, make_addr(tag, idx, off[2:0]), w);
    end
  endtask

  initial begin
    clk0     = 1'b0;
    init     = 1'b1;
    lookup   = 1'b0;
    fill     = 1'b0;
    addr     = '0;
    fill_way = 1'b0;
    lfsr     = 32'h3ca078c5;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk0);
    @(negedge clk0);
    init = 1'b0;
    run_directed();
    run_random();
    repeat (4) idle();   // Let the last responses out
    @(posedge clk0);
    if (next_check == pending.size() && next_check > 0) begin
      $display("%0d lookup responses checked", next_check);
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Run ended with %0d of %0d lookups never answered",
               pending.size() - next_check, pending.size());
      $display("TEST RESULT: FAIL");
      $fatal(1, "missing responses");
    end
  end

endmodule

// File: all.f
+incdir+include
design/itag_pkg.sv
design/itag_if.sv
design/tag_sram.sv
design/lru_array.sv
design/hit_select.sv
design/itag_top.sv
testbench/tb_itag.sv

// File: run.sh
#!/bin/sh
# Build and run the tag store testbench with Verilator
# Exit status is nonzero when the testbench ends in $fatal
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f all.f --top-module tb_itag \
  -Mdir obj_dir -o sim_itag

./obj_dir/sim_itag
